// ==== src/merge_pkg.sv ====
// merge lane shared types
`default_nettype none

package merge_pkg;

    // ----------------------------------------------------------------------
    // widths
    // ----------------------------------------------------------------------
    localparam int ADDR_W    = 16;
    localparam int SHIFT_W   = 4;
    localparam int NUM_LANES = 4;
    localparam int LANE_W    = 8;
    localparam int RESULT_W  = 16;
    localparam int WORD_W    = NUM_LANES * LANE_W;

    // bits left over in a setup word after mask and type
    localparam int CFG_RSVD_W = WORD_W - NUM_LANES - 2;

    // ----------------------------------------------------------------------
    // encodings
    // ----------------------------------------------------------------------
    typedef enum logic [1:0] {
        KIND_NONE         = 2'd0,
        KIND_CU_SETUP     = 2'd1,
        KIND_ENGINE_SETUP = 2'd2,
        KIND_DATA         = 2'd3
    } packet_kind_e;

    typedef enum logic [1:0] {
        MERGE_SUM = 2'd0,
        MERGE_MAX = 2'd1,
        MERGE_MIN = 2'd2,
        MERGE_OR  = 2'd3
    } merge_type_e;

    // ----------------------------------------------------------------------
    // data word, seen as lanes or as a setup field
    // ----------------------------------------------------------------------
    typedef logic [NUM_LANES-1:0][LANE_W-1:0] lane_array_t;

    // mask sits in the low bits
    typedef struct packed {
        logic [CFG_RSVD_W-1:0] reserved;
        merge_type_e           mtype;
        logic [NUM_LANES-1:0]  mask;
    } setup_word_t;

    typedef union packed {
        lane_array_t lanes;
        setup_word_t cfg;
    } engine_word_u;

    // ----------------------------------------------------------------------
    // packets and records
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic               valid;
        packet_kind_e       kind;
        logic [ADDR_W-1:0]  offset;
        logic [SHIFT_W-1:0] shift;
        engine_word_u       data;
    } engine_packet_t;

    typedef struct packed {
        logic [NUM_LANES-1:0] mask;
        merge_type_e          mtype;
    } merge_config_t;

    typedef struct packed {
        logic                valid;
        logic [RESULT_W-1:0] value;
    } merge_result_t;

endpackage

`default_nettype wire

// ==== src/merge_config_capture.sv ====
// setup word capture
`default_nettype none

module merge_config_capture #(
    parameter int SEQ_BASE  = 16,
    parameter int SEQ_WIDTH = 4
) (
    input  logic                      ap_clk,
    input  logic                      rst,
    input  merge_pkg::engine_packet_t packet,
    output logic                      cfg_wr,
    output merge_pkg::merge_config_t  cfg_din
);

    // one past the last sequence of this lane's window
    localparam int unsigned SEQ_END = SEQ_BASE + SEQ_WIDTH;

    // ----------------------------------------------------------------------
    // signals
    // ----------------------------------------------------------------------
    logic [merge_pkg::ADDR_W-1:0] seq;
    logic [31:0]                  seq_ext;
    logic                         is_setup;
    logic                         in_window;
    logic                         is_base;
    logic                         accept;

    // one-hot, bit k set means the next accepted word fills slot k
    logic [SEQ_WIDTH-1:0] slot_q;
    logic                 wr_q;

    // record fields under assembly
    logic [merge_pkg::NUM_LANES-1:0] mask_q;
    merge_pkg::merge_type_e          mtype_q;

    // ----------------------------------------------------------------------
    // sequence and filter
    // ----------------------------------------------------------------------
    assign seq     = packet.offset >> packet.shift;
    assign seq_ext = 32'(seq);

    assign is_setup = (packet.kind == merge_pkg::KIND_CU_SETUP) ||
                      (packet.kind == merge_pkg::KIND_ENGINE_SETUP);

    assign in_window = (seq_ext >= 32'(SEQ_BASE)) && (seq_ext < SEQ_END);

    assign is_base = (seq_ext == 32'(SEQ_BASE));

    assign accept = packet.valid && is_setup && in_window;

    // ----------------------------------------------------------------------
    // slot tracking
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (rst) begin
            slot_q <= '0;
            wr_q   <= 1'b0;
        end else begin
            wr_q <= 1'b0;
            if (accept && is_base) begin
                // base word took slot 0, slot 1 comes next
                slot_q <= SEQ_WIDTH'(2);
            end else if (accept && (slot_q != '0)) begin
                if (slot_q[SEQ_WIDTH-1]) begin
                    // final slot filled, hand the record over
                    slot_q <= '0;
                    wr_q   <= 1'b1;
                end else begin
                    slot_q <= slot_q << 1;
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // field latches
    // ----------------------------------------------------------------------

    // slot 0 carries the lane mask
    always_ff @(posedge ap_clk) begin
        if (accept && is_base) begin
            mask_q <= packet.data.cfg.mask;
        end
    end

    // slot 1 carries the merge type, later slots are only counted
    always_ff @(posedge ap_clk) begin
        if (accept && !is_base && slot_q[1]) begin
            mtype_q <= packet.data.cfg.mtype;
        end
    end

    // ----------------------------------------------------------------------
    // outputs
    // ----------------------------------------------------------------------
    assign cfg_wr = wr_q;

    always_comb begin
        cfg_din.mask  = mask_q;
        cfg_din.mtype = mtype_q;
    end

endmodule

`default_nettype wire

// ==== src/merge_config_fifo.sv ====
// configuration record FIFO
`default_nettype none

module merge_config_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                     ap_clk,
    input  logic                     rst,
    input  logic                     wr,
    input  merge_pkg::merge_config_t din,
    input  logic                     rd,
    output merge_pkg::merge_config_t dout,
    output logic                     empty,
    output logic                     full,
    output logic                     busy,
    output logic                     overflow
);

    localparam int PTR_W       = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W       = $clog2(FIFO_DEPTH + 1);
    localparam int BUSY_CYCLES = 4;
    localparam int BUSY_W      = $clog2(BUSY_CYCLES + 1);

    merge_pkg::merge_config_t mem [FIFO_DEPTH];

    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic [BUSY_W-1:0] busy_cnt;
    logic              wr_ok;
    logic              rd_ok;
    logic              overflow_q;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // ----------------------------------------------------------------------
    // status
    // ----------------------------------------------------------------------
    assign empty = (count == '0);
    assign full  = (count == CNT_W'(FIFO_DEPTH));
    assign busy  = (busy_cnt != '0);

    // nothing moves while the FIFO is clearing
    assign wr_ok = wr && !full && !busy;
    assign rd_ok = rd && !empty && !busy;

    // first word falls through
    assign dout     = mem[rd_ptr];
    assign overflow = overflow_q;

    // ----------------------------------------------------------------------
    // pointers and count
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            overflow_q <= 1'b0;
            busy_cnt   <= BUSY_W'(BUSY_CYCLES);
        end else begin
            overflow_q <= wr && (full || busy);
            if (busy_cnt != '0) begin
                busy_cnt <= busy_cnt - 1'b1;
            end
            if (wr_ok) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd_ok) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge ap_clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= din;
        end
    end

endmodule

`default_nettype wire

// ==== src/merge_data_engine.sv ====
// lane merge engine
`default_nettype none

module merge_data_engine (
    input  logic                      ap_clk,
    input  logic                      rst,
    input  merge_pkg::engine_packet_t packet,
    input  merge_pkg::merge_config_t  cfg_dout,
    input  logic                      cfg_empty,
    input  logic                      cfg_busy,
    output logic                      cfg_rd,
    output merge_pkg::merge_result_t  result
);

    // zero bits that widen a lane to the result width
    localparam int PAD_W = merge_pkg::RESULT_W - merge_pkg::LANE_W;

    merge_pkg::merge_config_t active_cfg;

    // input stage
    logic                     stage_valid;
    merge_pkg::engine_word_u  stage_word;
    merge_pkg::merge_config_t stage_cfg;

    // result stage
    logic                            result_valid_q;
    logic [merge_pkg::RESULT_W-1:0] result_value_q;

    // ----------------------------------------------------------------------
    // reduction over the masked lanes
    // ----------------------------------------------------------------------
    function automatic logic [merge_pkg::RESULT_W-1:0] reduce_lanes(
        input merge_pkg::engine_word_u  word,
        input merge_pkg::merge_config_t cfg
    );
        logic [merge_pkg::RESULT_W-1:0] acc;
        logic [merge_pkg::RESULT_W-1:0] lane;
        // min starts at the largest lane value, so an empty mask gives 255
        if (cfg.mtype == merge_pkg::MERGE_MIN) begin
            acc = {{PAD_W{1'b0}}, {merge_pkg::LANE_W{1'b1}}};
        end else begin
            acc = '0;
        end
        for (int i = 0; i < merge_pkg::NUM_LANES; i++) begin
            lane = {{PAD_W{1'b0}}, word.lanes[i]};
            if (cfg.mask[i]) begin
                case (cfg.mtype)
                    merge_pkg::MERGE_SUM: acc = acc + lane;
                    merge_pkg::MERGE_MAX: acc = (lane > acc) ? lane : acc;
                    merge_pkg::MERGE_MIN: acc = (lane < acc) ? lane : acc;
                    default:              acc = acc | lane;
                endcase
            end
        end
        return acc;
    endfunction

    // ----------------------------------------------------------------------
    // configuration
    // ----------------------------------------------------------------------

    // pop whenever a record is waiting
    assign cfg_rd = !cfg_empty && !cfg_busy;

    always_ff @(posedge ap_clk) begin
        if (rst) begin
            active_cfg.mask  <= '1;
            active_cfg.mtype <= merge_pkg::MERGE_SUM;
        end else if (cfg_rd) begin
            active_cfg <= cfg_dout;
        end
    end

    // ----------------------------------------------------------------------
    // data pipeline
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (rst) begin
            stage_valid    <= 1'b0;
            result_valid_q <= 1'b0;
        end else begin
            stage_valid    <= packet.valid && (packet.kind == merge_pkg::KIND_DATA);
            result_valid_q <= stage_valid;
        end
    end

    // config is bound to the word as it enters
    always_ff @(posedge ap_clk) begin
        stage_word     <= packet.data;
        stage_cfg      <= active_cfg;
        result_value_q <= reduce_lanes(stage_word, stage_cfg);
    end

    always_comb begin
        result.valid = result_valid_q;
        result.value = result_value_q;
    end

endmodule

`default_nettype wire

// ==== src/merge_data_top.sv ====
// merge lane top level
`default_nettype none

module merge_data_top #(
    parameter int SEQ_BASE   = 16,
    parameter int SEQ_WIDTH  = 4,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                      ap_clk,
    input  logic                      rst,
    input  merge_pkg::engine_packet_t packet_in,
    output merge_pkg::merge_result_t  merge_out,
    output logic                      cfg_empty,
    output logic                      setup_busy,
    output logic                      cfg_overflow
);

    // ----------------------------------------------------------------------
    // input register
    // ----------------------------------------------------------------------
    logic                      packet_valid_q;
    merge_pkg::engine_packet_t packet_body_q;
    merge_pkg::engine_packet_t packet_q;

    logic                     cfg_wr;
    merge_pkg::merge_config_t cfg_din;
    merge_pkg::merge_config_t cfg_dout;
    logic                     cfg_rd;

    always_ff @(posedge ap_clk) begin
        if (rst) begin
            packet_valid_q <= 1'b0;
        end else begin
            packet_valid_q <= packet_in.valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        packet_body_q <= packet_in;
    end

    always_comb begin
        packet_q       = packet_body_q;
        packet_q.valid = packet_valid_q;
    end

    // ----------------------------------------------------------------------
    // producer, buffer, consumer
    // ----------------------------------------------------------------------
    merge_config_capture #(
        .SEQ_BASE  (SEQ_BASE),
        .SEQ_WIDTH (SEQ_WIDTH)
    ) capture0 (
        .ap_clk  (ap_clk),
        .rst     (rst),
        .packet  (packet_q),
        .cfg_wr  (cfg_wr),
        .cfg_din (cfg_din)
    );

    // full only guards writes inside the FIFO
    merge_config_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo0 (
        .ap_clk   (ap_clk),
        .rst      (rst),
        .wr       (cfg_wr),
        .din      (cfg_din),
        .rd       (cfg_rd),
        .dout     (cfg_dout),
        .empty    (cfg_empty),
        .full     (),
        .busy     (setup_busy),
        .overflow (cfg_overflow)
    );

    merge_data_engine engine0 (
        .ap_clk    (ap_clk),
        .rst       (rst),
        .packet    (packet_q),
        .cfg_dout  (cfg_dout),
        .cfg_empty (cfg_empty),
        .cfg_busy  (setup_busy),
        .cfg_rd    (cfg_rd),
        .result    (merge_out)
    );

endmodule

`default_nettype wire

// ==== verif/merge_checker.sv ====
// merge lane result checker
`default_nettype none

module merge_checker #(
    parameter int SEQ_BASE  = 16,
    parameter int SEQ_WIDTH = 4
) (
    input logic                      ap_clk,
    input logic                      rst,
    input merge_pkg::engine_packet_t packet_in,
    input merge_pkg::merge_result_t  merge_out,
    input logic                      cfg_empty,
    input logic                      cfg_overflow
);
    timeunit 1ns;
    timeprecision 1ps;

    merge_pkg::merge_config_t model_cfg;
    merge_pkg::merge_config_t build_cfg;
    merge_pkg::merge_config_t pend_cfg[$];
    int                       pend_cyc[$];
    int                       expect_q[$];
    int                       slot = -1;
    int                       cyc = 0;
    int                       errors = 0;
    int                       errors_before = 0;
    int                       tests_run = 0;
    int                       tests_failed = 0;
    logic                     armed = 1'b0;
    logic                     rst_d = 1'b0;

    // engine rule, worked from the list of selected lane values
    function automatic int expected_result(input merge_pkg::engine_word_u word,
                                           input merge_pkg::merge_config_t cfg);
        int vals[merge_pkg::NUM_LANES];
        int n;
        int res;
        n = 0;
        for (int i = 0; i < merge_pkg::NUM_LANES; i++) begin
            if (cfg.mask[i]) begin
                vals[n] = int'(word.lanes[i]);
                n++;
            end
        end
        if (n == 0) begin
            return (cfg.mtype == merge_pkg::MERGE_MIN) ? 255 : 0;
        end
        res = vals[0];
        for (int k = 1; k < n; k++) begin
            case (cfg.mtype)
                merge_pkg::MERGE_SUM: res = res + vals[k];
                merge_pkg::MERGE_MAX: res = (vals[k] > res) ? vals[k] : res;
                merge_pkg::MERGE_MIN: res = (vals[k] < res) ? vals[k] : res;
                default:              res = res | vals[k];
            endcase
        end
        return res;
    endfunction

    task automatic check_value(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("ERR %0t ns %0s expected %0d actual %0d", $time, name, expected, actual);
            errors++;
        end
    endtask

    // ----------------------------------------------------------------------
    // sampling at the rising edge, inputs settle at the falling edge
    // ----------------------------------------------------------------------
    always @(posedge ap_clk) begin : watch
        int seq;
        cyc++;
        if (armed) begin
            check_value("cfg_overflow", int'(cfg_overflow), 0);
            // FIFO holds something only while a record is on its way
            if (pend_cyc.size() == 0) begin
                check_value("cfg_empty", int'(cfg_empty), 1);
            end
        end
        if (rst_d) begin
            check_value("merge_out.valid", int'(merge_out.valid), 0);
        end else if (armed && merge_out.valid) begin
            if (expect_q.size() == 0) begin
                $display("result %0d arrived at %0t ns with no data word outstanding",
                         merge_out.value, $time);
                errors++;
            end else begin
                check_value("merge_out.value", int'(merge_out.value), expect_q.pop_front());
            end
        end
        if (rst) begin
            model_cfg.mask  = '1;
            model_cfg.mtype = merge_pkg::MERGE_SUM;
            slot = -1;
            expect_q.delete();
            pend_cfg.delete();
            pend_cyc.delete();
        end else begin
            // record goes live three edges after its last word
            while (pend_cyc.size() > 0 && pend_cyc[0] <= cyc) begin
                model_cfg = pend_cfg.pop_front();
                pend_cyc.delete(0);
            end
            if (packet_in.valid && packet_in.kind == merge_pkg::KIND_DATA) begin
                expect_q.push_back(expected_result(packet_in.data, model_cfg));
            end
            seq = int'(packet_in.offset >> packet_in.shift);
            if (packet_in.valid && seq >= SEQ_BASE && seq < SEQ_BASE + SEQ_WIDTH &&
                (packet_in.kind == merge_pkg::KIND_CU_SETUP ||
                 packet_in.kind == merge_pkg::KIND_ENGINE_SETUP)) begin
                if (seq == SEQ_BASE) begin
                    build_cfg.mask = packet_in.data.cfg.mask;
                    slot = 1;
                end else if (slot > 0) begin
                    if (slot == 1) begin
                        build_cfg.mtype = packet_in.data.cfg.mtype;
                    end
                    if (slot == SEQ_WIDTH - 1) begin
                        pend_cfg.push_back(build_cfg);
                        pend_cyc.push_back(cyc + 3);
                        slot = -1;
                    end else begin
                        slot++;
                    end
                end
            end
        end
        armed = armed || rst;
        rst_d = rst;
    end

    function automatic int outstanding();
        return expect_q.size();
    endfunction

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %0s: ok", name);
        end else begin
            tests_failed++;
            $display("test %0s: %0d errors", name, errors - errors_before);
        end
        errors_before = errors;
    endtask

    task automatic close_run(output bit ok);
        if (expect_q.size() != 0) begin
            $display("%0d expected results were never produced", expect_q.size());
            errors++;
        end
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        ok = (errors == 0);
    endtask

endmodule

`default_nettype wire

// ==== verif/merge_tb_top.sv ====
// merge lane testbench
`default_nettype none

module merge_tb_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SEQ_BASE   = 16;
    localparam int SEQ_WIDTH  = 4;
    localparam int WAIT_LIMIT = 100;

    logic                      ap_clk = 1'b0;
    logic                      rst;
    merge_pkg::engine_packet_t packet_in;
    merge_pkg::merge_result_t  merge_out;
    logic                      cfg_empty;
    logic                      setup_busy;
    logic                      cfg_overflow;
    logic [15:0]               lfsr;
    logic [31:0]               rnd;
    logic [3:0]                cfg_mask;
    bit                        run_ok;

    always #50 ap_clk = ~ap_clk;

    merge_data_top #(
        .SEQ_BASE  (SEQ_BASE),
        .SEQ_WIDTH (SEQ_WIDTH)
    ) dut0 (
        .ap_clk       (ap_clk),
        .rst          (rst),
        .packet_in    (packet_in),
        .merge_out    (merge_out),
        .cfg_empty    (cfg_empty),
        .setup_busy   (setup_busy),
        .cfg_overflow (cfg_overflow)
    );

    merge_checker #(
        .SEQ_BASE  (SEQ_BASE),
        .SEQ_WIDTH (SEQ_WIDTH)
    ) chk0 (
        .ap_clk       (ap_clk),
        .rst          (rst),
        .packet_in    (packet_in),
        .merge_out    (merge_out),
        .cfg_empty    (cfg_empty),
        .cfg_overflow (cfg_overflow)
    );

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_bits(input int n);
        rnd = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            rnd  = {rnd[30:0], lfsr[0]};
        end
    endtask

    // ----------------------------------------------------------------------
    // stimulus, driven on the falling edge
    // ----------------------------------------------------------------------
    task automatic send_packet(input merge_pkg::packet_kind_e kind, input int seq,
                               input int shift, input logic [31:0] word);
        @(negedge ap_clk);
        packet_in.valid  = 1'b1;
        packet_in.kind   = kind;
        // low bits below the shift are filled and must not matter
        packet_in.offset = 16'((seq << shift) | ((1 << shift) - 1));
        packet_in.shift  = 4'(shift);
        packet_in.data   = word;
    endtask

    task automatic go_idle();
        @(negedge ap_clk);
        packet_in.valid = 1'b0;
    endtask

    task automatic send_setup(input merge_pkg::packet_kind_e kind, input int seq,
                              input int shift, input logic [3:0] mask,
                              input merge_pkg::merge_type_e mtype);
        merge_pkg::engine_word_u w;
        random_bits(32);
        w           = rnd;
        w.cfg.mask  = mask;
        w.cfg.mtype = mtype;
        send_packet(kind, seq, shift, w);
    endtask

    task automatic send_window(input merge_pkg::packet_kind_e kind, input int first,
                               input int shift, input logic [3:0] mask,
                               input merge_pkg::merge_type_e mtype);
        for (int s = 0; s < SEQ_WIDTH; s++) begin
            send_setup(kind, first + s, shift, mask, mtype);
        end
    endtask

    task automatic stream_data(input int n);
        for (int i = 0; i < n; i++) begin
            random_bits(32);
            send_packet(merge_pkg::KIND_DATA, 0, 0, rnd);
        end
    endtask

    task automatic send_data_words(input int n);
        stream_data(n);
        go_idle();
    endtask

    task automatic wait_for(input string what, input int level);
        int n;
        int cur;
        n   = 0;
        cur = -1;
        while (cur != level && n < WAIT_LIMIT) begin
            @(negedge ap_clk);
            n++;
            if (what == "setup_busy") begin
                cur = int'(setup_busy);
            end else if (what == "cfg_empty") begin
                cur = int'(cfg_empty);
            end else begin
                cur = chk0.outstanding();
            end
        end
        if (cur != level) begin
            $display("timeout after %0d cycles waiting for %0s to reach %0d", n, what, level);
            $display("TEST FAIL");
            $finish;
        end
    endtask

    // record written, then popped into the engine
    task automatic wait_applied();
        go_idle();
        wait_for("cfg_empty", 0);
        wait_for("cfg_empty", 1);
    endtask

    task automatic load_config(input logic [3:0] mask, input merge_pkg::merge_type_e mtype);
        send_window(merge_pkg::KIND_CU_SETUP, SEQ_BASE, 0, mask, mtype);
        wait_applied();
    endtask

    task automatic end_test(input string name);
        wait_for("results", 0);
        chk0.finish_test(name);
    endtask

    initial begin
        rst       = 1'b1;
        packet_in = '0;
        lfsr      = 16'd46;
        repeat (5) @(posedge ap_clk);
        @(negedge ap_clk);
        rst = 1'b0;

        // FIFO clears for four cycles after reset drops
        for (int k = 0; k < 4; k++) begin
            chk0.check_value("setup_busy", int'(setup_busy), 1);
            @(negedge ap_clk);
        end

        // defaults after reset sum all four lanes
        wait_for("setup_busy", 0);
        send_data_words(6);
        end_test("reset state");

        for (int t = 0; t < 4; t++) begin
            random_bits(4);
            load_config(rnd[3:0], merge_pkg::merge_type_e'(t));
            send_data_words(6);
            load_config(4'b0000, merge_pkg::merge_type_e'(t));
            send_data_words(2);
        end
        end_test("merge types");

        // none of these windows may change the record
        load_config(4'b1011, merge_pkg::MERGE_MAX);
        send_window(merge_pkg::KIND_DATA, SEQ_BASE, 0, 4'b0001, merge_pkg::MERGE_MIN);
        send_window(merge_pkg::KIND_NONE, SEQ_BASE, 0, 4'b0001, merge_pkg::MERGE_MIN);
        // open assembly stays one slot short unless a stray word counts
        send_setup(merge_pkg::KIND_CU_SETUP, SEQ_BASE, 0, 4'b0001, merge_pkg::MERGE_MIN);
        send_window(merge_pkg::KIND_CU_SETUP, SEQ_BASE - SEQ_WIDTH, 0, 4'b0001,
                    merge_pkg::MERGE_MIN);
        send_window(merge_pkg::KIND_ENGINE_SETUP, SEQ_BASE + SEQ_WIDTH, 0, 4'b0001,
                    merge_pkg::MERGE_MIN);
        for (int s = 1; s < SEQ_WIDTH - 1; s++) begin
            send_setup(merge_pkg::KIND_CU_SETUP, SEQ_BASE + s, 0, 4'b0001,
                       merge_pkg::MERGE_MIN);
        end
        send_data_words(8);
        end_test("filtering");

        random_bits(4);
        send_window(merge_pkg::KIND_ENGINE_SETUP, SEQ_BASE, 3, rnd[3:0], merge_pkg::MERGE_MIN);
        wait_applied();
        send_data_words(6);
        // base word again, the second assembly wins
        send_setup(merge_pkg::KIND_CU_SETUP, SEQ_BASE, 0, 4'b0110, merge_pkg::MERGE_MAX);
        send_setup(merge_pkg::KIND_CU_SETUP, SEQ_BASE + 1, 0, 4'b0110, merge_pkg::MERGE_MAX);
        send_window(merge_pkg::KIND_CU_SETUP, SEQ_BASE, 0, 4'b1101, merge_pkg::MERGE_OR);
        wait_applied();
        send_data_words(6);
        end_test("shift and restart");

        // every stage busy, record slips in between data words
        stream_data(6);
        random_bits(4);
        cfg_mask = rnd[3:0];
        for (int s = 0; s < SEQ_WIDTH; s++) begin
            send_setup(merge_pkg::KIND_CU_SETUP, SEQ_BASE + s, 0, cfg_mask, merge_pkg::MERGE_SUM);
            stream_data(1);
        end
        send_data_words(8);
        wait_for("cfg_empty", 1);
        end_test("streaming");

        chk0.close_run(run_ok);
        if (run_ok) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
src/merge_pkg.sv
src/merge_config_capture.sv
src/merge_config_fifo.sv
src/merge_data_engine.sv
src/merge_data_top.sv
verif/merge_checker.sv
verif/merge_tb_top.sv
